/* common/ex2If.sv */
// ==============================
// EX2 helper ports
// Stage side starts an operation,
// unit side answers with done and
// the result
// ==============================

`timescale 1ns/1ps
`include "ex2_defs.svh"

// Stage to memory-access unit
interface memPortIf;
	logic                 start;	// One-cycle request
	logic                 store;	// High for a write
	logic [`EX2_XLEN-1:0] addr;
	logic [`EX2_XLEN-1:0] storeData;
	logic                 done;	// One-cycle completion
	logic [`EX2_XLEN-1:0] loadData;

	modport stage (output start, store, addr, storeData, input done, loadData);
	modport unit (input start, store, addr, storeData, output done, loadData);
endinterface

// Stage to multiplier
interface mulPortIf;
	logic                 start;
	logic [`EX2_MULW-1:0] opA;
	logic [`EX2_MULW-1:0] opB;
	logic                 done;	// Product valid this cycle
	logic [`EX2_XLEN-1:0] product;

	modport stage (output start, opA, opB, input done, product);
	modport unit (input start, opA, opB, output done, product);
endinterface

/* common/ex2Pkg.sv */
// ==============================
// EX2 types
// Micro-op codes seen by EX2 and
// the multiplier FSM states
// ==============================

package ex2Pkg;

	// Micro-op handed over from EX1
	typedef enum logic [2:0] {
		UcNop   = 3'd0,	// Bubble
		UcAlu   = 3'd1,	// EX1 result plus T
		UcCmp   = 3'd2,	// T only
		UcMul   = 3'd3,	// 32x32 unsigned
		UcLoad  = 3'd4,	// 64-bit load
		UcStore = 3'd5,	// 64-bit store
		UcSleep = 3'd6	// Fixed stall
	} uCmd;

	// Shift-add multiplier sequencing
	typedef enum logic [1:0] {
		MulIdle = 2'd0,	// Waiting for start
		MulRun  = 2'd1,	// One bit per clock
		MulDone = 2'd2	// Product valid, done high
	} mulState;

endpackage

/* common/ex2_defs.svh */
// ==============================
// EX2 shared parameters
// Widths, reserved ids and fixed
// latencies for the second execute
// stage and its helpers
// ==============================

`ifndef EX2_DEFS_SVH
`define EX2_DEFS_SVH

// Datapath width of the core
`define EX2_XLEN 64

// Register id width and the id that discards writes
`define EX2_RIDW 6
`define EX2_ZZR 0

// Held cycles for a SLEEP micro-op
`define EX2_SLEEPCYC 15

// Multiplier operand width, product is twice this
`define EX2_MULW 32

`endif

/* hdl/ex2/ex2Stage.sv */
// ==============================
// ex2Stage
// Second execute stage. Decodes
// the micro-op, drives the helpers,
// raises hold and registers the
// write-back and the T flag
// ==============================

`timescale 1ns/1ps
`include "ex2_defs.svh"

module ex2Stage (
	input  logic                 clock,
	input  logic                 arstN,
	input  logic                 opValid,
	input  logic                 braFlush,
	input  logic                 aluSrT,
	input  ex2Pkg::uCmd          opCmd,
	input  logic [`EX2_RIDW-1:0] regIdRn,
	input  logic [`EX2_XLEN-1:0] regValRs,
	input  logic [`EX2_XLEN-1:0] regValRt,
	input  logic [`EX2_XLEN-1:0] regValRm,
	input  logic [`EX2_XLEN-1:0] aluRes,
	output logic                 hold,
	output logic                 regValid2,
	output logic                 srT,
	output logic [`EX2_RIDW-1:0] regIdRn2,
	output logic [`EX2_XLEN-1:0] regValRn2,
	memPortIf.stage              mem,
	mulPortIf.stage              mul
);

	import ex2Pkg::*;

	localparam int SleepW = $clog2(`EX2_SLEEPCYC + 1);
	localparam logic [SleepW-1:0] SleepLen = SleepW'(`EX2_SLEEPCYC);
	localparam logic [`EX2_RIDW-1:0] ZeroReg = `EX2_RIDW'(`EX2_ZZR);

	logic                 live;	// Op present and not cancelled
	logic                 busy;	// Helper already started for this op
	logic [SleepW-1:0]    sleepCnt;
	logic                 writes;	// Op produces a register result
	logic                 setsT;
	logic [`EX2_XLEN-1:0] wbVal;
	logic                 accept;
	logic                 wbEn;

	assign live = opValid && !braFlush;

	// Decode
	always_comb begin
		hold   = 1'b0;
		writes = 1'b0;
		setsT  = 1'b0;
		wbVal  = aluRes;	// ALU result forwarded by default
		case (opCmd)
			UcAlu: begin
				writes = 1'b1;
				setsT  = 1'b1;
			end
			UcCmp: setsT = 1'b1;	// Flag only
			UcMul: begin
				hold   = !mul.done;
				writes = 1'b1;
				wbVal  = mul.product;
			end
			UcLoad: begin
				hold   = !mem.done;
				writes = 1'b1;
				wbVal  = mem.loadData;
			end
			UcStore: hold = !mem.done;
			UcSleep: hold = (sleepCnt != SleepLen);
			default: ;	// Nop
		endcase
		if (!live)
			hold = 1'b0;	// Flushed or empty slot never stalls
	end

	// Helper requests, one start per op
	assign mul.start = live && !busy && (opCmd == UcMul);
	assign mul.opA   = regValRs[`EX2_MULW-1:0];
	assign mul.opB   = regValRt[`EX2_MULW-1:0];

	assign mem.start     = live && !busy && (opCmd == UcLoad || opCmd == UcStore);
	assign mem.store     = (opCmd == UcStore);
	assign mem.addr      = regValRs + regValRt;	// Base plus index
	assign mem.storeData = regValRm;

	assign accept = opValid && !hold;
	assign wbEn   = accept && !braFlush && writes && (regIdRn != ZeroReg);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			busy      <= 1'b0;
			sleepCnt  <= '0;
			regValid2 <= 1'b0;
			regIdRn2  <= ZeroReg;
			srT       <= 1'b0;
		end else begin
			busy <= hold;	// Clears on the accepting edge
			if (hold && opCmd == UcSleep)
				sleepCnt <= sleepCnt + 1'b1;
			else
				sleepCnt <= '0;
			regValid2 <= wbEn;
			regIdRn2  <= wbEn ? regIdRn : ZeroReg;
			if (accept && !braFlush && setsT)
				srT <= aluSrT;
		end
	end

	always_ff @(posedge clock)
		regValRn2 <= wbVal;	// Qualified by regValid2

	// EX1 keeps the held op in place
	aHoldStable: assert property (@(posedge clock) disable iff (!arstN)
		hold |=> opValid && $stable(opCmd) && $stable(regIdRn));

endmodule

/* hdl/ex2/memAccess.sv */
// ==============================
// memAccess
// Wishbone classic master, one
// 64-bit load or store per start
// ==============================

`timescale 1ns/1ps
`include "ex2_defs.svh"

module memAccess (
	input  logic                 clock,
	input  logic                 arstN,
	memPortIf.unit               mem,
	output logic                 busCyc,
	output logic                 busStb,
	output logic                 busWe,
	output logic [`EX2_XLEN-1:0] busAdr,
	output logic [`EX2_XLEN-1:0] busDatWr,
	input  logic [`EX2_XLEN-1:0] busDatRd,
	input  logic                 busAck
);

	logic                 ackSeen;	// Slave accepted the open cycle
	logic                 doneQ;
	logic [`EX2_XLEN-1:0] rdData;

	assign ackSeen = busStb && busAck;

	// Cycle control
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			busCyc <= 1'b0;
			busStb <= 1'b0;
			busWe  <= 1'b0;
			doneQ  <= 1'b0;
		end else begin
			doneQ <= 1'b0;	// Pulse only
			if (mem.start) begin
				busCyc <= 1'b1;	// cyc and stb rise together
				busStb <= 1'b1;
				busWe  <= mem.store;
			end else if (ackSeen) begin
				busCyc <= 1'b0;	// Drop the clock after ack
				busStb <= 1'b0;
				doneQ  <= 1'b1;
			end
		end
	end

	// Request payload and captured read data
	always_ff @(posedge clock) begin
		if (mem.start) begin
			busAdr   <= mem.addr;
			busDatWr <= mem.storeData;
		end
		if (ackSeen && !busWe)
			rdData <= busDatRd;	// Read data valid on the ack clock
	end

	assign mem.done     = doneQ;
	assign mem.loadData = rdData;

	// Slave acks only an open strobe
	aAckInCycle: assert property (@(posedge clock) disable iff (!arstN)
		busAck |-> busCyc && busStb);

	// Stage must wait for done before the next request
	aNoStartOpen: assert property (@(posedge clock) disable iff (!arstN)
		mem.start |-> !busCyc);

endmodule

/* hdl/ex2/mulUnit.sv */
// ==============================
// mulUnit
// Iterative shift-add multiplier
// 32x32 unsigned to 64 bits
// ==============================

`timescale 1ns/1ps
`include "ex2_defs.svh"

module mulUnit (
	input  logic clock,
	input  logic arstN,
	mulPortIf.unit mul
);

	import ex2Pkg::*;

	localparam int CntW = $clog2(`EX2_MULW);
	localparam logic [CntW-1:0] LastStep = CntW'(`EX2_MULW - 1);

	mulState              state;
	logic [CntW-1:0]      stepCnt;	// Multiplier bit in progress
	logic [`EX2_XLEN-1:0] acc;	// Partial product
	logic [`EX2_XLEN-1:0] mcand;	// Multiplicand, shifts left
	logic [`EX2_MULW-1:0] mplr;	// Multiplier, shifts right

	// Sequencing, MULW run cycles then one done cycle
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state   <= MulIdle;
			stepCnt <= '0;
		end else begin
			case (state)
				MulIdle: begin
					if (mul.start) begin
						state   <= MulRun;
						stepCnt <= '0;
					end
				end
				MulRun: begin
					stepCnt <= stepCnt + 1'b1;
					if (stepCnt == LastStep)
						state <= MulDone;
				end
				MulDone: state <= MulIdle;	// Single done cycle
				default: state <= MulIdle;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clock) begin
		if (state == MulIdle && mul.start) begin
			acc   <= '0;
			mcand <= `EX2_XLEN'(mul.opA);	// Zero extend
			mplr  <= mul.opB;
		end else if (state == MulRun) begin
			if (mplr[0])
				acc <= acc + mcand;
			mcand <= mcand << 1;
			mplr  <= mplr >> 1;
		end
	end

	assign mul.done    = (state == MulDone);
	assign mul.product = acc;	// Held until the next start

	// Stage must not restart a busy multiplier
	aStartIdle: assert property (@(posedge clock) disable iff (!arstN)
		mul.start |-> state == MulIdle);

endmodule

/* hdl/ex2Top.sv */
// ==============================
// ex2Top
// EX2 stage with its memory and
// multiply helpers on plain ports
// ==============================

`timescale 1ns/1ps
`include "ex2_defs.svh"

module ex2Top (
	input  logic                 clock,
	input  logic                 arstN,
	input  logic                 opValid,
	input  ex2Pkg::uCmd          opCmd,
	input  logic [`EX2_RIDW-1:0] regIdRn,
	input  logic [`EX2_XLEN-1:0] regValRs,
	input  logic [`EX2_XLEN-1:0] regValRt,
	input  logic [`EX2_XLEN-1:0] regValRm,
	input  logic [`EX2_XLEN-1:0] aluRes,
	input  logic                 aluSrT,
	input  logic                 braFlush,
	output logic                 hold,
	output logic                 regValid2,
	output logic [`EX2_RIDW-1:0] regIdRn2,
	output logic [`EX2_XLEN-1:0] regValRn2,
	output logic                 srT,
	output logic                 busCyc,
	output logic                 busStb,
	output logic                 busWe,
	output logic [`EX2_XLEN-1:0] busAdr,
	output logic [`EX2_XLEN-1:0] busDatWr,
	input  logic [`EX2_XLEN-1:0] busDatRd,
	input  logic                 busAck
);

	memPortIf memPort ();
	mulPortIf mulPort ();

	// Decode, hold and write-back
	ex2Stage stage0 (
		.clock     (clock),
		.arstN     (arstN),
		.opValid   (opValid),
		.braFlush  (braFlush),
		.aluSrT    (aluSrT),
		.opCmd     (opCmd),
		.regIdRn   (regIdRn),
		.regValRs  (regValRs),
		.regValRt  (regValRt),
		.regValRm  (regValRm),
		.aluRes    (aluRes),
		.hold      (hold),
		.regValid2 (regValid2),
		.srT       (srT),
		.regIdRn2  (regIdRn2),
		.regValRn2 (regValRn2),
		.mem       (memPort.stage),
		.mul       (mulPort.stage)
	);

	memAccess mem0 (
		.clock    (clock),
		.arstN    (arstN),
		.mem      (memPort.unit),
		.busCyc   (busCyc),
		.busStb   (busStb),
		.busWe    (busWe),
		.busAdr   (busAdr),
		.busDatWr (busDatWr),
		.busDatRd (busDatRd),
		.busAck   (busAck)
	);

	mulUnit mul0 (
		.clock (clock),
		.arstN (arstN),
		.mul   (mulPort.unit)
	);

endmodule

/* list.f */
+incdir+common
common/ex2Pkg.sv
common/ex2If.sv
hdl/ex2/memAccess.sv
hdl/ex2/mulUnit.sv
hdl/ex2/ex2Stage.sv
hdl/ex2Top.sv
verification/wbMemModel.sv
verification/ex2Tb.sv

/* verification/ex2Tb.sv */
// ==============================
// ex2Tb
// Directed testbench for ex2Top
// ALU, compare, multiply, memory,
// sleep and flush behaviour
// ==============================

`timescale 1ns/1ps
`include "ex2_defs.svh"

module ex2Tb;

	import ex2Pkg::*;

	localparam int MaxCycles = 2000;	// ~40 multiplies plus the memory tests
	localparam int NumAlu = 12;
	localparam int NumMul = 8;
	localparam int NumMem = 6;

	logic                 clock, arstN, opValid, braFlush, aluSrT;
	uCmd                  opCmd;
	logic [`EX2_RIDW-1:0] regIdRn, regIdRn2;
	logic [`EX2_XLEN-1:0] regValRs, regValRt, regValRm, aluRes, regValRn2;
	logic                 hold, regValid2, srT;
	logic                 busCyc, busStb, busWe, busAck;
	logic [`EX2_XLEN-1:0] busAdr, busDatWr, busDatRd;
	logic [1:0]           ackDelay;
	logic [31:0]          lcgState;
	int                   errCount, checkCount, testCount, cycleCount;

	ex2Top dut0 (.*);

	wbMemModel slave0 (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Run limit
	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= MaxCycles) begin
			$display("Timeout: the run did not finish within %0d cycles", MaxCycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic checkId(input string name, input logic [`EX2_RIDW-1:0] exp,
			input logic [`EX2_RIDW-1:0] act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("Error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic checkVal(input string name, input logic [`EX2_XLEN-1:0] exp,
			input logic [`EX2_XLEN-1:0] act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// Id falls back to the zero register when nothing is written
	task automatic checkWb(input string name, input logic expValid,
			input logic [`EX2_RIDW-1:0] rn, input logic [`EX2_XLEN-1:0] val);
		checkFlag({name, " valid"}, expValid, regValid2);
		checkId({name, " id"}, expValid ? rn : `EX2_RIDW'(`EX2_ZZR), regIdRn2);
		if (expValid)
			checkVal({name, " value"}, val, regValRn2);
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testCount++;
		if (errCount == errBefore)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, errCount - errBefore);
	endtask

	task automatic setOp(input uCmd cmd, input logic [`EX2_RIDW-1:0] rn,
			input logic [`EX2_XLEN-1:0] rs, rt, rm, alu, input logic t);
		opValid  = 1'b1;
		opCmd    = cmd;
		regIdRn  = rn;
		regValRs = rs;
		regValRt = rt;
		regValRm = rm;
		aluRes   = alu;
		aluSrT   = t;
	endtask

	task automatic idle();
		opValid  = 1'b0;
		opCmd    = UcNop;
		braFlush = 1'b0;
	endtask

	// Present one op and count its held cycles
	task automatic runOp(input uCmd cmd, input logic [`EX2_RIDW-1:0] rn,
			input logic [`EX2_XLEN-1:0] rs, rt, rm, alu, input logic t,
			output int holdCycles);
		@(negedge clock);
		setOp(cmd, rn, rs, rt, rm, alu, t);
		#1;
		holdCycles = 0;
		while (hold) begin
			holdCycles++;
			@(negedge clock);
			#1;
		end
		@(negedge clock);	// One negedge after acceptance
		idle();
	endtask

	task automatic resetChecks();
		int errBefore;
		errBefore = errCount;
		checkFlag("reset hold", 1'b0, hold);
		checkFlag("reset regValid2", 1'b0, regValid2);
		checkFlag("reset busCyc", 1'b0, busCyc);
		checkFlag("reset busStb", 1'b0, busStb);
		checkFlag("reset srT", 1'b0, srT);
		reportTest("reset", errBefore);
	endtask

	// 1. ALU ops every cycle without bubbles
	task automatic aluBackToBack();
		int errBefore;
		logic [31:0] r;
		logic [`EX2_RIDW-1:0] rn, prevRn;
		logic [`EX2_XLEN-1:0] alu, prevAlu;
		logic t, prevT;
		errBefore = errCount;
		for (int i = 0; i <= NumAlu; i++) begin
			@(negedge clock);
			if (i > 0) begin
				checkWb("alu", prevRn != `EX2_RIDW'(`EX2_ZZR), prevRn, prevAlu);
				checkFlag("alu T", prevT, srT);
			end
			if (i == NumAlu) begin
				idle();
			end else begin
				r   = nextRand();
				rn  = r[`EX2_RIDW-1:0];
				t   = r[16];
				alu = {nextRand(), nextRand()};
				setOp(UcAlu, rn, {32'h0, nextRand()}, {32'h0, nextRand()}, '0, alu, t);
				#1;
				checkFlag("alu hold", 1'b0, hold);
				prevRn  = rn;
				prevAlu = alu;
				prevT   = t;
			end
		end
		reportTest("alu", errBefore);
	endtask

	// 2. Compare writes only T
	task automatic cmpFlagOnly();
		int errBefore;
		int hc;
		logic t;
		errBefore = errCount;
		for (int i = 0; i < 4; i++) begin
			t = (i % 3 == 0);	// 1, 0, 0, 1
			runOp(UcCmp, 6'd9, '0, '0, '0, 64'hFFFF, t, hc);
			checkVal("cmp hold cycles", 64'd0, 64'(hc));
			checkFlag("cmp T", t, srT);
			checkFlag("cmp valid", 1'b0, regValid2);
		end
		reportTest("cmp", errBefore);
	endtask

	// 3. Multiply with junk in the upper source bits
	task automatic mulProduct();
		int errBefore;
		int hc;
		logic [31:0] a, b;
		logic [`EX2_RIDW-1:0] rn;
		errBefore = errCount;
		for (int i = 0; i < NumMul; i++) begin
			a  = (i == 0) ? 32'hFFFF_FFFF : nextRand();	// Largest case first
			b  = (i == 0) ? 32'hFFFF_FFFF : nextRand();
			rn = `EX2_RIDW'(i + 1);
			runOp(UcMul, rn, {nextRand(), a}, {nextRand(), b}, '0, '0, 1'b0, hc);
			checkVal("mul hold cycles", 64'(`EX2_MULW + 1), 64'(hc));
			checkWb("mul", 1'b1, rn, 64'(a) * 64'(b));
		end
		reportTest("mul", errBefore);
	endtask

	// 4. Store then load back through a different base/index split
	task automatic storeLoad();
		int errBefore;
		int hc;
		logic [`EX2_XLEN-1:0] addr, data, rt, k;
		errBefore = errCount;
		for (int i = 0; i < NumMem; i++) begin
			addr = {nextRand(), nextRand()};
			rt   = 64'(nextRand() & 32'h0FFF);
			k    = 64'(nextRand() & 32'h00FF);
			data = {nextRand(), nextRand()};
			ackDelay = 2'(i);
			runOp(UcStore, 6'd12, addr - rt, rt, data, '0, 1'b0, hc);
			checkVal("store hold cycles", 64'(i % 4 + 2), 64'(hc));	// start, waits+1, done
			checkWb("store", 1'b0, 6'd12, '0);
			checkVal("store memory word", data, slave0.mem[addr[10:3]]);
			ackDelay = 2'(3 - i % 4);
			runOp(UcLoad, 6'd13, addr - k, k, '0, '0, 1'b0, hc);
			checkVal("load hold cycles", 64'(3 - i % 4 + 2), 64'(hc));
			checkWb("load", 1'b1, 6'd13, data);
		end
		reportTest("mem", errBefore);
	endtask

	// 5. Fixed stall, twice so the counter must restart
	task automatic sleepStall();
		int errBefore;
		int hc;
		errBefore = errCount;
		runOp(UcSleep, 6'd5, '0, '0, '0, '0, 1'b0, hc);
		checkVal("sleep hold cycles", 64'(`EX2_SLEEPCYC), 64'(hc));
		checkWb("sleep", 1'b0, 6'd5, '0);
		runOp(UcSleep, 6'd6, '0, '0, '0, '0, 1'b0, hc);
		checkVal("second sleep hold cycles", 64'(`EX2_SLEEPCYC), 64'(hc));
		reportTest("sleep", errBefore);
	endtask

	// 6. Flushed ops leave no trace and the next ones complete
	task automatic flushCancel();
		int errBefore;
		int hc;
		logic oldT;
		errBefore = errCount;
		@(negedge clock);
		setOp(UcMul, 6'd7, 64'd3, 64'd5, '0, '0, 1'b0);
		braFlush = 1'b1;
		#1;
		checkFlag("flush mul hold", 1'b0, hold);
		checkFlag("flush mul start", 1'b0, dut0.mulPort.start);
		@(negedge clock);
		checkWb("flush mul", 1'b0, 6'd7, '0);
		oldT = srT;
		setOp(UcAlu, 6'd8, '0, '0, '0, 64'h1234, ~oldT);
		#1;
		checkFlag("flush alu hold", 1'b0, hold);
		@(negedge clock);
		checkWb("flush alu", 1'b0, 6'd8, '0);
		checkFlag("flush alu T", oldT, srT);
		idle();
		runOp(UcMul, 6'd10, 64'd1000, 64'd77, '0, '0, 1'b0, hc);
		checkVal("after flush mul hold cycles", 64'(`EX2_MULW + 1), 64'(hc));
		checkWb("after flush mul", 1'b1, 6'd10, 64'd77000);
		runOp(UcAlu, 6'd11, '0, '0, '0, 64'hDEAD_BEEF, ~oldT, hc);
		checkWb("after flush alu", 1'b1, 6'd11, 64'hDEAD_BEEF);
		checkFlag("after flush alu T", ~oldT, srT);
		reportTest("flush", errBefore);
	endtask

	initial begin
		arstN      = 1'b0;
		lcgState   = 32'd66151;
		errCount   = 0;
		checkCount = 0;
		testCount  = 0;
		cycleCount = 0;
		ackDelay   = 2'd0;
		setOp(UcNop, '0, '0, '0, '0, '0, 1'b0);
		idle();
		repeat (16) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
		@(negedge clock);
		resetChecks();
		aluBackToBack();
		cmpFlagOnly();
		mulProduct();
		storeLoad();
		sleepStall();
		flushCancel();
		$display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* verification/wbMemModel.sv */
// ==============================
// wbMemModel
// Wishbone classic slave memory
// 256 x 64 bit, ack after 0 to 3
// programmable wait cycles
// ==============================

`timescale 1ns/1ps
`include "ex2_defs.svh"

module wbMemModel (
	input  logic                 clock,
	input  logic                 arstN,
	input  logic                 busCyc,
	input  logic                 busStb,
	input  logic                 busWe,
	input  logic [`EX2_XLEN-1:0] busAdr,
	input  logic [`EX2_XLEN-1:0] busDatWr,
	output logic [`EX2_XLEN-1:0] busDatRd,
	output logic                 busAck,
	input  logic [1:0]           ackDelay	// Wait states before ack
);

	logic [`EX2_XLEN-1:0] mem [0:255];
	logic [1:0]           waitCnt;	// Waits spent on the open strobe

	// Fill depends on the full word index
	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = {32'hC0DE_0000 + 32'(i), ~32'(i)};
	end

	assign busAck   = busCyc && busStb && (waitCnt == ackDelay);
	assign busDatRd = mem[busAdr[10:3]];	// Word addressed

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			waitCnt <= '0;
		else if (busStb && !busAck)
			waitCnt <= waitCnt + 1'b1;
		else
			waitCnt <= '0;	// Idle or acked
	end

	always @(posedge clock) begin
		if (busStb && busAck && busWe)
			mem[busAdr[10:3]] <= busDatWr;
	end

endmodule
